/* design/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Data and address width of the integer datapath.
`define RV_XLEN 32

// Register index width, 32 architectural registers.
`define RV_REG_ADDR_W 5

`endif

/* design/rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decoded operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_addi,
		op_add,
		op_sub,
		op_illegal // Everything else, retires with no effect.
	} opcode_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [31:0]         inst;
		logic [`RV_XLEN-1:0] pc;
	} fetch_s;

	typedef struct packed {
		opcode_e                    op;
		logic [`RV_XLEN-1:0]        pc;
		logic [`RV_REG_ADDR_W-1:0]  rd;
		logic                       wen;
		logic [`RV_XLEN-1:0]        imm;  // Sign-extended by format.
		logic [`RV_XLEN-1:0]        src1;
		logic [`RV_XLEN-1:0]        src2;
	} decoded_s;

	typedef struct packed {
		logic [`RV_XLEN-1:0]        pc;
		logic [`RV_REG_ADDR_W-1:0]  rd;
		logic                       wen;
		logic [`RV_XLEN-1:0]        value;
	} retire_s;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
	} redirect_s;

endpackage

/* design/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_regfile (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`RV_REG_ADDR_W-1:0] rs1,
	input  logic [`RV_REG_ADDR_W-1:0] rs2,
	input  logic                      wb_wen,
	input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
	input  logic [`RV_XLEN-1:0]       wb_value,
	output logic [`RV_XLEN-1:0]       rs1_data,
	output logic [`RV_XLEN-1:0]       rs2_data
);

	localparam int num_regs = 1 << `RV_REG_ADDR_W;

	logic [`RV_XLEN-1:0] regs [1:num_regs-1]; // No storage for x0.

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_wen && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_value;
		end
	end

	// Combinational reads, no write bypass.
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/rv_decode.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_decode (
	input  logic                      clock,
	input  logic                      reset,
	input  rv_pkg::fetch_s            fetch,
	input  logic                      fetch_valid,
	output logic                      fetch_ready,
	output logic [`RV_REG_ADDR_W-1:0] rs1,
	output logic [`RV_REG_ADDR_W-1:0] rs2,
	input  logic [`RV_XLEN-1:0]       rs1_data,
	input  logic [`RV_XLEN-1:0]       rs2_data,
	input  logic [`RV_REG_ADDR_W-1:0] exe_rd,
	input  logic                      exe_wen,
	input  logic                      exe_valid,
	input  logic                      wb_wen,
	input  logic [`RV_XLEN-1:0]       wb_value,
	output rv_pkg::decoded_s          dec,
	output logic                      dec_valid,
	input  logic                      exe_ready,
	input  rv_pkg::redirect_s         redirect
);

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	logic [31:0]         inst;
	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	rv_pkg::opcode_e     op;
	logic                wen;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;
	logic                need_rs1;
	logic                need_rs2;
	logic                rs1_used;
	logic                rs2_used;
	logic                rs1_dec_hit;
	logic                rs2_dec_hit;
	logic                rs1_exe_hit;
	logic                rs2_exe_hit;
	logic                stall;
	logic                fetch_xfer;
	rv_pkg::decoded_s    dec_next;

	assign inst   = fetch.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode and immediate decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		op = rv_pkg::op_illegal;
		case (opcode)
			opc_lui:   op = rv_pkg::op_lui;
			opc_auipc: op = rv_pkg::op_auipc;
			opc_jal:   op = rv_pkg::op_jal;
			opc_jalr: begin
				if (funct3 == 3'b000) op = rv_pkg::op_jalr;
			end
			opc_branch: begin
				if (funct3 == 3'b000) op = rv_pkg::op_beq;
			end
			opc_op_imm: begin
				if (funct3 == 3'b000) op = rv_pkg::op_addi;
			end
			opc_op: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000) op = rv_pkg::op_add;
				if (funct3 == 3'b000 && funct7 == 7'b0100000) op = rv_pkg::op_sub;
			end
			default: op = rv_pkg::op_illegal;
		endcase
	end

	assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			opc_lui, opc_auipc:             imm = imm_u;
			opc_jal:                        imm = imm_j;
			opc_jalr, opc_load, opc_op_imm: imm = imm_i;
			opc_store:                      imm = imm_s;
			opc_branch:                     imm = imm_b;
			default:                        imm = '0;
		endcase
	end

	always_comb begin
		case (op)
			rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal, rv_pkg::op_jalr,
			rv_pkg::op_addi, rv_pkg::op_add, rv_pkg::op_sub: wen = 1'b1;
			default:                                          wen = 1'b0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RAW hazards and forwarding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign need_rs1 = (op != rv_pkg::op_lui) && (op != rv_pkg::op_auipc) &&
		(op != rv_pkg::op_jal);
	assign need_rs2 = (op == rv_pkg::op_beq) || (op == rv_pkg::op_add) ||
		(op == rv_pkg::op_sub);

	assign rs1_used = need_rs1 && (rs1 != '0);
	assign rs2_used = need_rs2 && (rs2 != '0);

	assign rs1_dec_hit = dec_valid && dec.wen && (dec.rd == rs1);
	assign rs2_dec_hit = dec_valid && dec.wen && (dec.rd == rs2);
	assign rs1_exe_hit = exe_valid && exe_wen && (exe_rd == rs1);
	assign rs2_exe_hit = exe_valid && exe_wen && (exe_rd == rs2);

	// wb_wen marks the execute instruction retiring now.
	assign stall = (rs1_used && (rs1_dec_hit || (rs1_exe_hit && !wb_wen))) ||
		(rs2_used && (rs2_dec_hit || (rs2_exe_hit && !wb_wen)));

	assign fetch_ready = !stall && (!dec_valid || exe_ready);
	assign fetch_xfer  = fetch_valid && fetch_ready;

	always_comb begin
		dec_next.op   = op;
		dec_next.pc   = fetch.pc;
		dec_next.rd   = inst[11:7];
		dec_next.wen  = wen;
		dec_next.imm  = imm;
		dec_next.src1 = (rs1_used && rs1_exe_hit && wb_wen) ? wb_value : rs1_data;
		dec_next.src2 = (rs2_used && rs2_exe_hit && wb_wen) ? wb_value : rs2_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (redirect.valid) begin
			dec_valid <= 1'b0; // Wrong path.
		end else if (fetch_xfer) begin
			dec_valid <= 1'b1;
		end else if (exe_ready) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_xfer && !redirect.valid) begin
			dec <= dec_next;
		end
	end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_execute (
	input  logic                      clock,
	input  logic                      reset,
	input  rv_pkg::decoded_s          dec,
	input  logic                      dec_valid,
	output logic                      exe_ready,
	output logic [`RV_REG_ADDR_W-1:0] exe_rd,
	output logic                      exe_wen,
	output logic                      exe_valid,
	output logic                      wb_wen,
	output logic [`RV_REG_ADDR_W-1:0] wb_rd,
	output logic [`RV_XLEN-1:0]       wb_value,
	output rv_pkg::retire_s           retire,
	output logic                      retire_valid,
	input  logic                      retire_ready,
	output rv_pkg::redirect_s         redirect
);

	localparam logic [`RV_XLEN-1:0] inst_bytes = 4;

	rv_pkg::decoded_s    held;
	logic [`RV_XLEN-1:0] value;
	logic [`RV_XLEN-1:0] pc_target;
	logic [`RV_XLEN-1:0] jalr_sum;
	logic                retire_xfer;
	logic                taken;

	assign exe_ready = !exe_valid || retire_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Holding register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			exe_valid <= 1'b0;
		end else if (exe_ready) begin
			exe_valid <= dec_valid && !redirect.valid; // Drop the wrong-path one.
		end
	end

	always_ff @(posedge clock) begin
		if (exe_ready && dec_valid && !redirect.valid) begin
			held <= dec;
		end
	end

	assign exe_rd  = held.rd;
	assign exe_wen = held.wen;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result and redirect
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (held.op)
			rv_pkg::op_lui:                 value = held.imm;
			rv_pkg::op_auipc:               value = held.pc + held.imm;
			rv_pkg::op_jal, rv_pkg::op_jalr: value = held.pc + inst_bytes; // Link.
			rv_pkg::op_addi:                value = held.src1 + held.imm;
			rv_pkg::op_add:                 value = held.src1 + held.src2;
			rv_pkg::op_sub:                 value = held.src1 - held.src2;
			default:                        value = '0;
		endcase
	end

	assign jalr_sum  = held.src1 + held.imm;
	assign pc_target = (held.op == rv_pkg::op_jalr) ?
		{jalr_sum[`RV_XLEN-1:1], 1'b0} : held.pc + held.imm;

	assign taken = (held.op == rv_pkg::op_jal) || (held.op == rv_pkg::op_jalr) ||
		((held.op == rv_pkg::op_beq) && (held.src1 == held.src2));

	assign retire_xfer  = exe_valid && retire_ready;
	assign retire_valid = exe_valid;

	always_comb begin
		retire.pc    = held.pc;
		retire.rd    = held.rd;
		retire.wen   = held.wen;
		retire.value = value;
	end

	assign redirect.valid = retire_xfer && taken; // One cycle only.
	assign redirect.pc    = pc_target;

	assign wb_wen   = retire_xfer && held.wen;
	assign wb_rd    = held.rd;
	assign wb_value = value;

endmodule

/* design/rv_core.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::fetch_s    fetch,
	input  logic              fetch_valid,
	output logic              fetch_ready,
	output rv_pkg::retire_s   retire,
	output logic              retire_valid,
	input  logic              retire_ready,
	output rv_pkg::redirect_s redirect
);

	logic [`RV_REG_ADDR_W-1:0] rs1;
	logic [`RV_REG_ADDR_W-1:0] rs2;
	logic [`RV_XLEN-1:0]       rs1_data;
	logic [`RV_XLEN-1:0]       rs2_data;
	rv_pkg::decoded_s          dec;
	logic                      dec_valid;
	logic                      exe_ready;
	logic [`RV_REG_ADDR_W-1:0] exe_rd;
	logic                      exe_wen;
	logic                      exe_valid;
	logic                      wb_wen;
	logic [`RV_REG_ADDR_W-1:0] wb_rd;
	logic [`RV_XLEN-1:0]       wb_value;

	rv_decode u_decode (
		.clock       (clock),
		.reset       (reset),
		.fetch       (fetch),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.rs1         (rs1),
		.rs2         (rs2),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.exe_rd      (exe_rd),
		.exe_wen     (exe_wen),
		.exe_valid   (exe_valid),
		.wb_wen      (wb_wen),
		.wb_value    (wb_value),
		.dec         (dec),
		.dec_valid   (dec_valid),
		.exe_ready   (exe_ready),
		.redirect    (redirect)     // Flush.
	);

	rv_regfile u_regfile (
		.clock    (clock),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.wb_wen   (wb_wen),
		.wb_rd    (wb_rd),
		.wb_value (wb_value),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	rv_execute u_execute (
		.clock        (clock),
		.reset        (reset),
		.dec          (dec),
		.dec_valid    (dec_valid),
		.exe_ready    (exe_ready),
		.exe_rd       (exe_rd),
		.exe_wen      (exe_wen),
		.exe_valid    (exe_valid),
		.wb_wen       (wb_wen),
		.wb_rd        (wb_rd),
		.wb_value     (wb_value),
		.retire       (retire),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.redirect     (redirect)
	);

endmodule

/* tb/rv_core_checker.sv */
`timescale 1ns/100ps

module rv_core_checker (
	input logic              clock,
	input logic              reset,
	input rv_pkg::retire_s   retire,
	input logic              retire_valid,
	input logic              retire_ready,
	input rv_pkg::redirect_s redirect
);

	int fail_count = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Retire and redirect handshakes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Quiet in reset and in the first cycle out of it.
	assert property (@(posedge clock)
		$past(reset) |-> (!retire_valid && !redirect.valid))
		else begin
			fail_count++;
			$error("retire or redirect active during or right after reset");
		end

	assert property (@(posedge clock) disable iff (reset)
		(retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
		else begin
			fail_count++;
			$error("retire payload changed while stalled"); // Hold rule.
		end

	assert property (@(posedge clock) disable iff (reset)
		redirect.valid |-> (retire_valid && retire_ready))
		else begin
			fail_count++;
			$error("redirect raised without a retire transfer");
		end

endmodule

/* tb/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

	localparam int prog_words     = 256;
	localparam int num_retires    = 2000;
	localparam int timeout_cycles = num_retires * 20;

	typedef enum int {k_lui, k_auipc, k_addi, k_add, k_sub, k_jal, k_jalr, k_beq,
		k_illegal} kind_e;

	logic              clock        = 1'b0;
	logic              reset        = 1'b1;
	rv_pkg::fetch_s    fetch        = '0;
	logic              fetch_valid  = 1'b0;
	logic              fetch_ready;
	rv_pkg::retire_s   retire;
	logic              retire_valid;
	logic              retire_ready = 1'b0;
	rv_pkg::redirect_s redirect;

	integer      seed        = 32'ha621_9f9c;
	int          error_count = 0;
	int          check_count = 0;
	int          retired     = 0;
	logic [31:0] prog [prog_words];
	kind_e       prog_kind [prog_words];
	logic [31:0] prog_imm [prog_words];
	logic [31:0] model_regs [32] = '{default: '0};
	logic [31:0] model_pc        = '0;

	rv_core u_rv_core (.*);

	bind rv_core rv_core_checker u_checker (.*);

	always #5 clock = ~clock;

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail %0t: %s at pc %h, got %h, expected %h", $time, what, model_pc,
				actual, expected);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random program
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic build_program();
		int          p;
		int          target;
		logic [31:0] r;
		logic [31:0] v;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		for (int i = 0; i < prog_words; i++) begin
			p      = {$random(seed)} % 15;
			r      = $random(seed);
			target = {$random(seed)} % prog_words;
			if (target == i) begin
				target = (i + 1) % prog_words; // No self loops.
			end
			rd  = {3'b000, r[8:7]}; // Only x0 to x3, so hazards are common.
			rs1 = {3'b000, r[16:15]};
			rs2 = {3'b000, r[21:20]};
			prog_kind[i] = kind_e'((p < 9) ? p : 2 + p % 3);
			case (prog_kind[i])
				k_lui, k_auipc: v = {r[31:12], 12'h000};
				k_addi:         v = {{20{r[31]}}, r[31:20]};
				k_jalr:         v = target * 4 + r[31]; // Odd sum tests bit 0 clear.
				default:        v = (target - i) * 4;
			endcase
			prog_imm[i] = v;
			case (prog_kind[i])
				k_lui:   prog[i] = {v[31:12], rd, 7'b0110111};
				k_auipc: prog[i] = {v[31:12], rd, 7'b0010111};
				k_addi:  prog[i] = {v[11:0], rs1, 3'b000, rd, 7'b0010011};
				k_add:   prog[i] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
				k_sub:   prog[i] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
				k_jal:   prog[i] = {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
				k_jalr:  prog[i] = {v[11:0], 5'd0, 3'b000, rd, 7'b1100111};
				k_beq:   prog[i] = {v[12], v[10:5], rs2, rs1, 3'b000, v[4:1], v[11],
					7'b1100011};
				default: prog[i] = r[0] ? {r[31:7], 7'b0000011} : // Load.
					{r[31:15], 3'b001, r[11:7], 7'b0010011};       // Shift immediate.
			endcase
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_retire();
		logic [31:0] word;
		logic [31:0] v;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] value;
		logic [31:0] next_pc;
		logic        wen;
		logic        taken;
		kind_e       k;
		word    = prog[model_pc[9:2]];
		v       = prog_imm[model_pc[9:2]];
		k       = prog_kind[model_pc[9:2]];
		src1    = model_regs[word[19:15]];
		src2    = model_regs[word[24:20]];
		value   = '0;
		wen     = 1'b1;
		taken   = 1'b0;
		next_pc = (model_pc + 4) & 32'h3ff; // Wraps to 0.
		case (k)
			k_lui:   value = v;
			k_auipc: value = model_pc + v;
			k_addi:  value = src1 + v;
			k_add:   value = src1 + src2;
			k_sub:   value = src1 - src2;
			k_jal, k_jalr: begin
				value   = model_pc + 4; // Link.
				taken   = 1'b1;
				next_pc = (k == k_jal) ? model_pc + v : (src1 + v) & ~32'h1;
			end
			k_beq: begin
				wen     = 1'b0;
				taken   = (src1 == src2);
				next_pc = taken ? model_pc + v : next_pc;
			end
			default: wen = 1'b0;
		endcase
		check_value(retire.pc, model_pc, "retire pc");
		check_value(32'(retire.wen), 32'(wen), "retire wen");
		if (wen) begin
			check_value(32'(retire.rd), 32'(word[11:7]), "retire rd");
			check_value(retire.value, value, "retire value");
		end
		check_value(32'(redirect.valid), 32'(taken), "redirect valid");
		if (taken) begin
			check_value(redirect.pc, next_pc, "redirect target");
		end
		if (wen && (word[11:7] != 5'd0)) begin
			model_regs[word[11:7]] = value; // x0 stays zero.
		end
		model_pc = next_pc;
		retired++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fetch model and retire back-pressure
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clock) begin : drive_inputs
		logic [31:0] draw;
		logic [31:0] next_pc;
		draw = $random(seed);
		if (reset) begin
			fetch_valid  <= 1'b0;
			fetch        <= '0;
			retire_ready <= 1'b0;
		end else begin
			if (redirect.valid) begin
				next_pc = redirect.pc; // Any transfer now is wrong path.
			end else if (fetch_valid && fetch_ready) begin
				next_pc = (fetch.pc + 4) & 32'h3ff;
			end else begin
				next_pc = fetch.pc;
			end
			if (redirect.valid || !fetch_valid || fetch_ready) begin
				fetch_valid <= (draw[1:0] != 2'b00);
				fetch.pc    <= next_pc;
				fetch.inst  <= prog[next_pc[9:2]];
			end
			retire_ready <= ((draw[31:8] % 10) >= 3); // Low about 30 percent.
		end
	end

	always @(posedge clock) begin
		if (!reset && retire_valid && retire_ready) begin
			check_retire();
		end
	end

	initial begin
		build_program();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		wait (retired >= num_retires);
		$display("Retired %0d, checks %0d, errors %0d, assertion failures %0d", retired,
			check_count, error_count, u_rv_core.u_checker.fail_count);
		if ((error_count == 0) && (u_rv_core.u_checker.fail_count == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("Timeout after %0d cycles, only %0d of %0d instructions retired",
			timeout_cycles, retired, num_retires);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
FAIL_MSG  ?= Simulation failed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
